//--- fpu_cases.txt
// op rm operand_a operand_b expected_result expected_nv
// One case per line, all columns hex
0 0 3fc00000 bf800000 bfc00000 0
0 1 3fc00000 bf800000 3fc00000 0
0 2 c0490fdb bf800000 40490fdb 0
1 0 7f800001 00000000 7f800001 0
2 3 ff812345 12345678 ff812345 0
3 0 80000000 00000000 80000000 0
3 1 80000000 00000000 00000000 0
3 0 7fc00000 40000000 40000000 0
3 1 7f800001 c0000000 c0000000 1
3 0 7fc00000 ffc00000 7fc00000 0
3 1 7f800001 7fc00000 7fc00000 1
3 0 c0400000 bf800000 c0400000 0
3 1 3f800000 40000000 40000000 0
4 0 3f800000 40000000 00000001 0
4 1 40000000 40000000 00000000 0
4 1 c0000000 bf800000 00000001 0
4 2 80000000 00000000 00000001 0
4 0 7fc00000 3f800000 00000000 1
4 2 7fc00000 7fc00000 00000000 0
4 2 7f800001 3f800000 00000000 1
6 0 3f800000 40000000 00000001 0
7 0 40000000 3f800000 00000001 0
8 0 3f800000 3f800000 00000000 0
6 0 7fc00000 3f800000 00000001 0
7 0 bf800000 7fc00000 00000001 1
5 0 ff800000 00000000 00000001 0
5 0 bf800000 00000000 00000002 0
5 0 80000001 00000000 00000004 0
5 0 80000000 00000000 00000008 0
5 0 00000000 00000000 00000010 0
5 0 007fffff 00000000 00000020 0
5 0 3f800000 00000000 00000040 0
5 0 7f800000 00000000 00000080 0
5 0 7f800001 00000000 00000100 0
5 0 7fc00000 00000000 00000200 0

//--- build.f
+incdir+.
fpu_pkg.sv
fpu_decode.sv
fpu_issue_buffer.sv
fpu_execute.sv
fpu_result.sv
fpu_top.sv
tb_fpu_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the FPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_fpu_top -o tb_fpu_top
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/tb_fpu_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- tb_fpu_top.sv
`default_nettype none

`include "fpu_settings.svh"

module tb_fpu_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES  = 64;
    localparam int CASE_WORDS = 6;  // op, rm, a, b, result, nv

    logic                        clk_i;
    logic                        rst_ni;
    logic                        flush_i;
    logic                        fpu_valid_i;
    logic                        fpu_ready_o;
    fpu_pkg::fpu_operator_e      operator_i;
    logic [2:0]                  rm_i;
    logic [`FPU_FLEN-1:0]        operand_a_i;
    logic [`FPU_FLEN-1:0]        operand_b_i;
    logic [`FPU_TAG_BITS-1:0]    trans_id_i;
    logic                        result_ready_i;
    logic                        fpu_valid_o;
    logic [`FPU_FLEN-1:0]        result_o;
    logic [`FPU_STATUS_BITS-1:0] status_o;
    logic [`FPU_TAG_BITS-1:0]    trans_id_o;

    logic [31:0] case_mem [0:CASE_WORDS*MAX_CASES-1];  // Flat case table
    logic [31:0] lfsr;
    int          num_cases;
    int          issued;         // Cases accepted by the DUT
    int          checked;        // Results taken from the DUT
    int          timeout_limit;
    int          cycle_count = 0;
    int          errors_result;
    int          errors_status;
    int          errors_tag;
    int          errors_other;

    fpu_top dut_i (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .fpu_valid_i    ( fpu_valid_i    ),
        .fpu_ready_o    ( fpu_ready_o    ),
        .operator_i     ( operator_i     ),
        .rm_i           ( rm_i           ),
        .operand_a_i    ( operand_a_i    ),
        .operand_b_i    ( operand_b_i    ),
        .trans_id_i     ( trans_id_i     ),
        .result_ready_i ( result_ready_i ),
        .fpu_valid_o    ( fpu_valid_o    ),
        .result_o       ( result_o       ),
        .status_o       ( status_o       ),
        .trans_id_o     ( trans_id_o     )
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;  // 20 ns period

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end else begin
            return state >> 1;
        end
    endfunction

    //------------------------------
    // Stimulus and checks
    //------------------------------
    task automatic drive_case(input int idx);
        if (idx < num_cases) begin
            fpu_valid_i = 1'b1;
            operator_i  = fpu_pkg::fpu_operator_e'(case_mem[CASE_WORDS*idx][3:0]);
            rm_i        = case_mem[CASE_WORDS*idx+1][2:0];
            operand_a_i = case_mem[CASE_WORDS*idx+2];
            operand_b_i = case_mem[CASE_WORDS*idx+3];
            trans_id_i  = idx[2:0];  // Tag is index modulo 8
        end else begin
            fpu_valid_i = 1'b0;      // Queue fully issued
        end
    endtask

    task automatic check_result(input int idx);
        logic [31:0]                 exp_result;
        logic [`FPU_STATUS_BITS-1:0] exp_status;
        exp_result = case_mem[CASE_WORDS*idx+4];
        exp_status = {case_mem[CASE_WORDS*idx+5][0], 4'b0000};  // Only NV can rise
        assert (result_o == exp_result) else begin
            errors_result++;
            $display("FAIL %0t: case %0d result %08h, expected %08h",
                     $time, idx, result_o, exp_result);
        end
        assert (status_o == exp_status) else begin
            errors_status++;
            $display("FAIL %0t: case %0d status %05b, expected %05b",
                     $time, idx, status_o, exp_status);
        end
        assert (trans_id_o == idx[2:0]) else begin
            errors_tag++;
            $display("FAIL %0t: case %0d tag %0d, expected %0d",
                     $time, idx, trans_id_o, idx[2:0]);
        end
    endtask

    always @(posedge clk_i) begin : p_timeout
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin : p_main
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        fpu_valid_i    = 1'b0;
        operator_i     = fpu_pkg::FSGNJ;
        rm_i           = 3'd0;
        operand_a_i    = '0;
        operand_b_i    = '0;
        trans_id_i     = '0;
        result_ready_i = 1'b0;
        lfsr           = 32'hcee3;
        errors_result  = 0;
        errors_status  = 0;
        errors_tag     = 0;
        errors_other   = 0;
        issued         = 0;
        checked        = 0;

        // Unused words read as f000_0000 plus their address
        for (int i = 0; i < CASE_WORDS*MAX_CASES; i++) begin
            case_mem[i] = 32'hf000_0000 | i;
        end
        $readmemh("fpu_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[CASE_WORDS*num_cases][31:28] != 4'hf) begin
            num_cases++;
        end
        timeout_limit = 20 * num_cases + 100;
        if (num_cases == 0) begin
            errors_other++;
            $display("No test cases could be read from fpu_cases.txt");
        end

        repeat (10) @(negedge clk_i);  // Reset held for 10 cycles
        rst_ni = 1'b1;

        // One pass per cycle with decisions taken mid low phase
        while (checked < num_cases) begin
            @(negedge clk_i);
            drive_case(issued);
            lfsr           = lfsr_step(lfsr);  // Fresh ready bit this cycle
            result_ready_i = lfsr[0];
            #5;
            if (fpu_valid_o && result_ready_i) begin
                check_result(checked);  // Results arrive in issue order
                checked++;
            end
            if (fpu_valid_i && fpu_ready_o) begin
                issued++;
            end
        end

        //------------------------------
        // Idle flush
        //------------------------------
        @(negedge clk_i);
        fpu_valid_i    = 1'b0;
        result_ready_i = 1'b1;
        flush_i        = 1'b1;
        #5;
        assert (fpu_ready_o) else begin
            errors_other++;
            $display("FAIL %0t: fpu_ready_o low during idle flush", $time);
        end
        @(negedge clk_i);
        flush_i = 1'b0;
        repeat (6) begin
            #5;
            assert (fpu_ready_o && !fpu_valid_o) else begin
                errors_other++;
                $display("FAIL %0t: ready %0b valid %0b after flush, expected ready 1 valid 0",
                         $time, fpu_ready_o, fpu_valid_o);
            end
            @(negedge clk_i);
        end

        $display("Errors: result %0d, status %0d, tag %0d, other %0d",
                 errors_result, errors_status, errors_tag, errors_other);
        if (errors_result + errors_status + errors_tag + errors_other == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fpu_top.sv
`default_nettype none

`include "fpu_settings.svh"

module fpu_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  logic                        fpu_valid_i,
    output logic                        fpu_ready_o,
    input  fpu_pkg::fpu_operator_e      operator_i,
    input  logic [2:0]                  rm_i,
    input  logic [`FPU_FLEN-1:0]        operand_a_i,
    input  logic [`FPU_FLEN-1:0]        operand_b_i,
    input  logic [`FPU_TAG_BITS-1:0]    trans_id_i,
    input  logic                        result_ready_i,
    output logic                        fpu_valid_o,
    output logic [`FPU_FLEN-1:0]        result_o,
    output logic [`FPU_STATUS_BITS-1:0] status_o,
    output logic [`FPU_TAG_BITS-1:0]    trans_id_o
);

    fpu_pkg::fpu_req_t dec_req;               // Decoded request
    fpu_pkg::fpu_req_t exec_req;              // Direct or held request
    logic              exec_valid, exec_ready;
    fpu_pkg::fpu_rsp_t rsp;
    logic              rsp_valid, rsp_ready;

    fpu_decode i_decode (
        .operator_i  ( operator_i  ),
        .rm_i        ( rm_i        ),
        .operand_a_i ( operand_a_i ),
        .operand_b_i ( operand_b_i ),
        .trans_id_i  ( trans_id_i  ),
        .req_o       ( dec_req     )
    );

    fpu_issue_buffer i_issue (
        .clk_i        ( clk_i       ),
        .rst_ni       ( rst_ni      ),
        .flush_i      ( flush_i     ),
        .valid_i      ( fpu_valid_i ),
        .ready_o      ( fpu_ready_o ),
        .req_i        ( dec_req     ),
        .exec_valid_o ( exec_valid  ),
        .exec_ready_i ( exec_ready  ),
        .exec_req_o   ( exec_req    )
    );

    fpu_execute i_execute (
        .clk_i       ( clk_i      ),
        .rst_ni      ( rst_ni     ),
        .flush_i     ( flush_i    ),
        .req_valid_i ( exec_valid ),
        .req_ready_o ( exec_ready ),
        .req_i       ( exec_req   ),
        .rsp_valid_o ( rsp_valid  ),
        .rsp_ready_i ( rsp_ready  ),
        .rsp_o       ( rsp        )
    );

    fpu_result i_result (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( flush_i        ),
        .rsp_valid_i    ( rsp_valid      ),
        .rsp_ready_o    ( rsp_ready      ),
        .rsp_i          ( rsp            ),
        .result_ready_i ( result_ready_i ),
        .valid_o        ( fpu_valid_o    ),
        .result_o       ( result_o       ),
        .status_o       ( status_o       ),
        .trans_id_o     ( trans_id_o     )
    );

endmodule

`default_nettype wire

//--- fpu_result.sv
`default_nettype none

`include "fpu_settings.svh"

module fpu_result (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    input  logic                     rsp_valid_i,
    output logic                     rsp_ready_o,
    input  fpu_pkg::fpu_rsp_t        rsp_i,
    input  logic                     result_ready_i,
    output logic                     valid_o,
    output logic [`FPU_FLEN-1:0]     result_o,
    output fpu_pkg::fpu_status_t     status_o,
    output logic [`FPU_TAG_BITS-1:0] trans_id_o
);

    logic              valid_q;
    fpu_pkg::fpu_rsp_t rsp_q;

    // Free when empty or when the consumer takes the current entry
    assign rsp_ready_o = ~valid_q | result_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // Drop pending result
        end else if (rsp_ready_o) begin
            valid_q <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (rsp_valid_i && rsp_ready_o) begin
            rsp_q <= rsp_i;
        end
    end

    // Status leaves beside the result word
    assign valid_o    = valid_q;
    assign result_o   = rsp_q.result;
    assign status_o   = rsp_q.status;
    assign trans_id_o = rsp_q.tag;

endmodule

`default_nettype wire

//--- fpu_execute.sv
`default_nettype none

`include "fpu_settings.svh"

module fpu_execute (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  fpu_pkg::fpu_req_t req_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output fpu_pkg::fpu_rsp_t rsp_o
);

    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_snan;
        logic is_qnan;
    } fp_class_t;

    typedef struct packed {
        fpu_pkg::fpu_req_t req;
        fp_class_t         class_a;
        fp_class_t         class_b;
    } stage1_t;

    function automatic fp_class_t classify(fpu_pkg::fp32_word_u w);
        fp_class_t c;
        logic      exp_ones;
        logic      exp_zero;
        logic      man_zero;
        exp_ones       = &w.fields.exponent;
        exp_zero       = ~|w.fields.exponent;
        man_zero       = ~|w.fields.mantissa;
        c.is_zero      = exp_zero & man_zero;
        c.is_subnormal = exp_zero & ~man_zero;
        c.is_normal    = ~exp_zero & ~exp_ones;
        c.is_inf       = exp_ones & man_zero;
        c.is_snan      = exp_ones & ~man_zero & ~w.fields.mantissa[22];  // Quiet bit clear
        c.is_qnan      = exp_ones & w.fields.mantissa[22];
        return c;
    endfunction

    logic                s1_valid_q, s2_valid_q;
    logic                s1_ready, s2_ready;
    stage1_t             s1_d, s1_q;
    fpu_pkg::fpu_rsp_t   rsp_d, rsp_q;
    fpu_pkg::fp32_word_u op_a, op_b;
    fp_class_t           cls_a, cls_b;
    logic                a_nan, b_nan, any_snan, both_zero;
    logic                mag_lt, mag_gt, lt_total, ieee_lt, ieee_eq, cmp_bit;

    //------------------------------
    // Handshake and valids
    //------------------------------
    assign s2_ready    = ~s2_valid_q | rsp_ready_i;  // Stage 2 drains or is empty
    assign s1_ready    = ~s1_valid_q | s2_ready;
    assign req_ready_o = s1_ready;
    assign rsp_valid_o = s2_valid_q;
    assign rsp_o       = rsp_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_ready) s1_valid_q <= req_valid_i;
            if (s2_ready) s2_valid_q <= s1_valid_q;
        end
    end

    // Stage 1 captures the request with both operand classes
    assign s1_d.req     = req_i;
    assign s1_d.class_a = classify(req_i.operand_a);
    assign s1_d.class_b = classify(req_i.operand_b);

    always_ff @(posedge clk_i) begin : p_payload
        if (req_valid_i && s1_ready) s1_q  <= s1_d;
        if (s1_valid_q && s2_ready)  rsp_q <= rsp_d;
    end

    //------------------------------
    // Stage 2 operations
    //------------------------------
    assign op_a      = s1_q.req.operand_a;
    assign op_b      = s1_q.req.operand_b;
    assign cls_a     = s1_q.class_a;
    assign cls_b     = s1_q.class_b;
    assign a_nan     = cls_a.is_snan | cls_a.is_qnan;
    assign b_nan     = cls_b.is_snan | cls_b.is_qnan;
    assign any_snan  = cls_a.is_snan | cls_b.is_snan;
    assign both_zero = cls_a.is_zero & cls_b.is_zero;
    assign mag_lt    = op_a.bits[`FPU_FLEN-2:0] < op_b.bits[`FPU_FLEN-2:0];
    assign mag_gt    = op_b.bits[`FPU_FLEN-2:0] < op_a.bits[`FPU_FLEN-2:0];

    // Total order with -0 below +0 and negative magnitudes reversed
    assign lt_total = (op_a.fields.sign != op_b.fields.sign) ? op_a.fields.sign :
                      (op_a.fields.sign ? mag_gt : mag_lt);
    assign ieee_lt  = lt_total & ~both_zero;                   // -0 == +0 for compares
    assign ieee_eq  = (op_a.bits == op_b.bits) | both_zero;

    always_comb begin : p_compute
        rsp_d.result = op_a.bits;
        rsp_d.status = '0;
        rsp_d.tag    = s1_q.req.tag;
        cmp_bit      = 1'b0;

        case (s1_q.req.unit_op)
            fpu_pkg::SGNJ: begin
                case (s1_q.req.sub_op)
                    `FPU_SGNJ_J:  rsp_d.result = {op_b.fields.sign, op_a.bits[`FPU_FLEN-2:0]};
                    `FPU_SGNJ_JN: rsp_d.result = {~op_b.fields.sign, op_a.bits[`FPU_FLEN-2:0]};
                    `FPU_SGNJ_JX: rsp_d.result = {op_a.fields.sign ^ op_b.fields.sign,
                                                  op_a.bits[`FPU_FLEN-2:0]};
                    default:      rsp_d.result = op_a.bits;  // Move passthrough
                endcase
            end
            fpu_pkg::MINMAX: begin
                rsp_d.status.nv = any_snan;
                if (a_nan && b_nan) begin
                    rsp_d.result = `FPU_CANON_NAN;
                end else if (a_nan) begin
                    rsp_d.result = op_b.bits;  // Non-NaN side wins
                end else if (b_nan) begin
                    rsp_d.result = op_a.bits;
                end else if (s1_q.req.sub_op == `FPU_MINMAX_MAX) begin
                    rsp_d.result = lt_total ? op_b.bits : op_a.bits;
                end else begin
                    rsp_d.result = lt_total ? op_a.bits : op_b.bits;
                end
            end
            fpu_pkg::CMP: begin
                case (s1_q.req.sub_op)
                    `FPU_CMP_LE: begin
                        cmp_bit         = ieee_lt | ieee_eq;
                        rsp_d.status.nv = a_nan | b_nan;  // Signalling compare
                    end
                    `FPU_CMP_LT: begin
                        cmp_bit         = ieee_lt;
                        rsp_d.status.nv = a_nan | b_nan;
                    end
                    `FPU_CMP_EQ: begin
                        cmp_bit         = ieee_eq;
                        rsp_d.status.nv = any_snan;       // Quiet compare
                    end
                    default: cmp_bit = 1'b0;
                endcase
                if (a_nan || b_nan) cmp_bit = 1'b0;  // Unordered
                rsp_d.result = {{(`FPU_FLEN-1){1'b0}}, cmp_bit ^ s1_q.req.op_mod};
            end
            default: begin
                // Ten-bit class mask with -inf in bit 0
                rsp_d.result = {{(`FPU_FLEN-10){1'b0}},
                                cls_a.is_qnan,
                                cls_a.is_snan,
                                ~op_a.fields.sign & cls_a.is_inf,
                                ~op_a.fields.sign & cls_a.is_normal,
                                ~op_a.fields.sign & cls_a.is_subnormal,
                                ~op_a.fields.sign & cls_a.is_zero,
                                op_a.fields.sign & cls_a.is_zero,
                                op_a.fields.sign & cls_a.is_subnormal,
                                op_a.fields.sign & cls_a.is_normal,
                                op_a.fields.sign & cls_a.is_inf};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fpu_issue_buffer.sv
`default_nettype none

module fpu_issue_buffer (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              flush_i,
    input  logic              valid_i,
    output logic              ready_o,
    input  fpu_pkg::fpu_req_t req_i,
    output logic              exec_valid_o,
    input  logic              exec_ready_i,
    output fpu_pkg::fpu_req_t exec_req_o
);

    typedef enum logic {READY, STALL} state_e;

    state_e            state_q, state_d;
    logic              hold_en;   // Capture incoming request
    logic              use_hold;  // Present captured request
    fpu_pkg::fpu_req_t hold_q;

    //------------------------------
    // Protocol inversion FSM
    //------------------------------
    always_comb begin : p_fsm
        ready_o      = 1'b0;
        exec_valid_o = 1'b0;
        hold_en      = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        case (state_q)
            READY: begin
                ready_o      = 1'b1;     // Look ready to the issuer
                exec_valid_o = valid_i;  // Pass request straight on
                // Request arrives but execute is full
                if (valid_i && !exec_ready_i) begin
                    ready_o = 1'b0;  // Withhold the token
                    hold_en = 1'b1;
                    state_d = STALL;
                end
            end
            STALL: begin
                exec_valid_o = 1'b1;
                use_hold     = 1'b1;
                // Token handed out on the edge that drains the hold
                if (exec_ready_i) begin
                    ready_o = 1'b1;
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        if (flush_i) begin
            state_d = READY;  // Flush wins over everything
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold register loaded only by the FSM
    always_ff @(posedge clk_i) begin : p_hold
        if (hold_en) begin
            hold_q <= req_i;
        end
    end

    assign exec_req_o = use_hold ? hold_q : req_i;

endmodule

`default_nettype wire

//--- fpu_decode.sv
`default_nettype none

`include "fpu_settings.svh"

module fpu_decode (
    input  fpu_pkg::fpu_operator_e    operator_i,
    input  logic [2:0]                rm_i,
    input  logic [`FPU_FLEN-1:0]      operand_a_i,
    input  logic [`FPU_FLEN-1:0]      operand_b_i,
    input  logic [`FPU_TAG_BITS-1:0]  trans_id_i,
    output fpu_pkg::fpu_req_t         req_o
);

    //------------------------------
    // Operator translation
    //------------------------------
    always_comb begin : p_decode
        // Default is sign injection with the sub-op straight from rm
        req_o.operand_a.bits = operand_a_i;
        req_o.operand_b.bits = operand_b_i;
        req_o.unit_op        = fpu_pkg::SGNJ;
        req_o.sub_op         = rm_i[1:0];  // rm[2] carries no meaning here
        req_o.op_mod         = 1'b0;
        req_o.tag            = trans_id_i;

        case (operator_i)
            fpu_pkg::FSGNJ: begin
                req_o.unit_op = fpu_pkg::SGNJ;  // J / JN / JX in rm
            end
            fpu_pkg::FMV_F2X,
            fpu_pkg::FMV_X2F: begin
                // Moves are a passthrough of operand a
                req_o.unit_op = fpu_pkg::SGNJ;
                req_o.sub_op  = `FPU_SGNJ_PASS;
            end
            fpu_pkg::FMIN_MAX: begin
                req_o.unit_op = fpu_pkg::MINMAX;  // Min or max in rm
            end
            fpu_pkg::FCMP: begin
                req_o.unit_op = fpu_pkg::CMP;     // LE / LT / EQ in rm
            end
            fpu_pkg::FCLASS: begin
                req_o.unit_op = fpu_pkg::CLASSIFY;
            end
            fpu_pkg::FNE: begin
                req_o.unit_op = fpu_pkg::CMP;
                req_o.sub_op  = `FPU_CMP_EQ;
                req_o.op_mod  = 1'b1;  // Not equal
            end
            fpu_pkg::FGE: begin
                req_o.unit_op = fpu_pkg::CMP;
                req_o.sub_op  = `FPU_CMP_LT;
                req_o.op_mod  = 1'b1;  // Not less than
            end
            fpu_pkg::FGT: begin
                req_o.unit_op = fpu_pkg::CMP;
                req_o.sub_op  = `FPU_CMP_LE;
                req_o.op_mod  = 1'b1;  // Not less or equal
            end
            default: begin
                // Unknown code falls back to sign injection
                req_o.unit_op = fpu_pkg::SGNJ;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- fpu_pkg.sv
`default_nettype none

`include "fpu_settings.svh"

package fpu_pkg;

    // Operator codes seen at the unit boundary
    typedef enum logic [`FPU_OP_BITS-1:0] {
        FSGNJ    = 4'd0,
        FMV_F2X  = 4'd1,
        FMV_X2F  = 4'd2,
        FMIN_MAX = 4'd3,
        FCMP     = 4'd4,
        FCLASS   = 4'd5,
        FNE      = 4'd6,  // Inverted EQ
        FGE      = 4'd7,  // Inverted LT
        FGT      = 4'd8   // Inverted LE
    } fpu_operator_e;

    // Internal unit operation after decode
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } fpu_unit_op_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // Operand word read raw or by field
    typedef union packed {
        logic [`FPU_FLEN-1:0] bits;
        fp32_fields_t         fields;
    } fp32_word_u;

    typedef struct packed {
        logic nv;  // Invalid
        logic dz;  // Divide by zero
        logic of;  // Overflow
        logic uf;  // Underflow
        logic nx;  // Inexact
    } fpu_status_t;

    typedef struct packed {
        fp32_word_u                operand_a;
        fp32_word_u                operand_b;
        fpu_unit_op_e              unit_op;
        logic [`FPU_SUBOP_BITS-1:0] sub_op;
        logic                      op_mod;   // Invert compare result
        logic [`FPU_TAG_BITS-1:0]  tag;
    } fpu_req_t;

    typedef struct packed {
        logic [`FPU_FLEN-1:0]     result;
        fpu_status_t              status;
        logic [`FPU_TAG_BITS-1:0] tag;
    } fpu_rsp_t;

endpackage

`default_nettype wire

//--- fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// Datapath widths
`define FPU_FLEN        32
`define FPU_TAG_BITS    3
`define FPU_STATUS_BITS 5  // NV DZ OF UF NX
`define FPU_OP_BITS     4
`define FPU_SUBOP_BITS  2

// Canonical quiet NaN
`define FPU_CANON_NAN   32'h7fc00000

// Sub-op encodings carried in rm[1:0]
`define FPU_SGNJ_J      2'd0
`define FPU_SGNJ_JN     2'd1
`define FPU_SGNJ_JX     2'd2
`define FPU_SGNJ_PASS   2'd3  // Plain move of operand a
`define FPU_MINMAX_MAX  2'd1  // 0 selects min
`define FPU_CMP_LE      2'd0
`define FPU_CMP_LT      2'd1
`define FPU_CMP_EQ      2'd2

`endif
